//--- rtl/mdecColorPkg.sv
// MDEC colour sample and pixel types
// Shared by the conversion stage, the pixel FIFO and the packer
// Samples come from the IDCT side as signed values
// Pixels leave the converter as three 8-bit channels

package mdecColorPkg;

	// Width of one colour channel in both samples and pixels
	localparam int COLOR_BITS = 8;

	// ------------------------------------------------------------
	// One decoded sample
	// ------------------------------------------------------------
	// All three fields already clamped to -128..127 by the IDCT
	typedef struct packed {
		logic signed [COLOR_BITS-1:0] y;
		logic signed [COLOR_BITS-1:0] cr;
		logic signed [COLOR_BITS-1:0] cb;
	} yuvSample_t;

	// ------------------------------------------------------------
	// One converted pixel
	// ------------------------------------------------------------
	// Signed or unsigned depending on the unsigned mode level
	typedef struct packed {
		logic [COLOR_BITS-1:0] r;
		logic [COLOR_BITS-1:0] g;
		logic [COLOR_BITS-1:0] b;
	} rgbPixel_t;

endpackage

//--- rtl/mdecOutPkg.sv
// MDEC output word types
// Describes the 32-bit word handed to the DMA side
// and the two pixel formats the packer can build

package mdecOutPkg;

	// Bits kept from each 8-bit channel in 15-bit mode
	localparam int FIELD15_BITS = 5;
	// Group position counter, four pixels per 24-bit group
	localparam int GROUP_BITS = 2;

	// Output pixel format
	typedef enum logic {
		FMT_15 = 1'b0,
		FMT_24 = 1'b1
	} outFormat_t;

	// 15-bit pixel as the GPU expects it, mask on top
	typedef struct packed {
		logic                    mask;
		logic [FIELD15_BITS-1:0] b;
		logic [FIELD15_BITS-1:0] g;
		logic [FIELD15_BITS-1:0] r;
	} rgb15_t;

	// Same 32 bits seen as a byte stream or as two 15-bit pixels
	// Byte 0 and half 0 hold the earliest data
	typedef union packed {
		logic [3:0][7:0] bytes;
		rgb15_t [1:0]    half;
	} outWord_t;

endpackage

//--- rtl/YUV2RGBCompute.sv
// YCbCr to RGB colour converter
// Purely combinational, one pixel per evaluation
// Chroma factors are 359/256, -88/256, -183/256 and 454/256
// Each channel saturates to -128..127, unsigned mode flips the sign bit
// Y-only mode removes the chroma contribution

`timescale 1ns/1ps

module YUV2RGBCompute (
	input  logic              i_YOnly,
	input  logic              i_unsigned,
	input  logic signed [7:0] i_valueY,
	input  logic signed [7:0] i_valueCr,
	input  logic signed [7:0] i_valueCb,
	output logic        [7:0] o_r,
	output logic        [7:0] o_g,
	output logic        [7:0] o_b
);

	// Clamp a wide signed sum to 8 bits, then pick signed or unsigned form
	function automatic logic [7:0] sat8(input logic signed [17:0] value, input logic flip);
		logic [7:0] clamped;
		if (value > 18'sd127) begin
			clamped = 8'h7F;
		end else if (value < -18'sd128) begin
			clamped = 8'h80;
		end else begin
			clamped = value[7:0];
		end
		// -128..127 maps to 0..255 by toggling the top bit
		return {clamped[7] ^ flip, clamped[6:0]};
	endfunction

	// ------------------------------------------------------------
	// Chroma factors in 1/256 steps
	// ------------------------------------------------------------
	logic signed [9:0]  rFact;
	logic signed [9:0]  gFactB;
	logic signed [9:0]  gFactR;
	logic signed [9:0]  bFact;
	// 8x10 signed products
	logic signed [17:0] rProd;
	logic signed [17:0] gProdB;
	logic signed [17:0] gProdR;
	logic signed [17:0] bProd;
	// Channel sums before saturation
	logic signed [17:0] sumR;
	logic signed [17:0] sumG;
	logic signed [17:0] sumB;

	assign rFact  = i_YOnly ? 10'sd0 : 10'sd359;
	assign gFactB = i_YOnly ? 10'sd0 : -10'sd88;
	assign gFactR = i_YOnly ? 10'sd0 : -10'sd183;
	assign bFact  = i_YOnly ? 10'sd0 : 10'sd454;

	// Four multipliers, no sharing
	assign rProd  = i_valueCr * rFact;
	assign gProdB = i_valueCb * gFactB;
	assign gProdR = i_valueCr * gFactR;
	assign bProd  = i_valueCb * bFact;

	// Each product drops its fraction on its own before the add
	assign sumR = (rProd >>> 8) + 18'(i_valueY);
	assign sumG = (gProdB >>> 8) + (gProdR >>> 8) + 18'(i_valueY);
	assign sumB = (bProd >>> 8) + 18'(i_valueY);

	// ------------------------------------------------------------
	// Saturation and output form
	// ------------------------------------------------------------
	assign o_r = sat8(sumR, i_unsigned);
	assign o_g = sat8(sumG, i_unsigned);
	assign o_b = sat8(sumB, i_unsigned);

endmodule

//--- rtl/colorConvStage.sv
// Colour conversion stage
// Converts each strobed sample and registers the pixel with its push strobe
// so the multipliers get a pipeline stage of their own
// A new sample may arrive on every clock

`timescale 1ns/1ps

module colorConvStage (
	input  logic                     i_clk,
	input  logic                     i_arstN,
	input  logic                     i_sampleValid,
	input  mdecColorPkg::yuvSample_t i_sample,
	input  logic                     i_yOnly,
	input  logic                     i_unsigned,
	output logic                     o_push,
	output mdecColorPkg::rgbPixel_t  o_pixel
);

	import mdecColorPkg::*;

	// Converter output for the sample on the input this cycle
	rgbPixel_t convPixel;

	YUV2RGBCompute uConv (
		.i_YOnly   (i_yOnly),
		.i_unsigned(i_unsigned),
		.i_valueY  (i_sample.y),
		.i_valueCr (i_sample.cr),
		.i_valueCb (i_sample.cb),
		.o_r       (convPixel.r),
		.o_g       (convPixel.g),
		.o_b       (convPixel.b)
	);

	// Push strobe follows the sample strobe by one clock
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			o_push <= 1'b0;
		end else begin
			o_push <= i_sampleValid;
		end
	end

	// Pixel payload, only loaded with a real sample
	always_ff @(posedge i_clk) begin
		if (i_sampleValid) begin
			o_pixel <= convPixel;
		end
	end

endmodule

//--- rtl/pixelFifo.sv
// Pixel FIFO
// Circular buffer between the conversion stage and the packer
// Pointers carry one extra wrap bit to tell full from empty
// Full and empty are registered levels

`timescale 1ns/1ps

module pixelFifo #(
	// Power of two, at least 2
	parameter int FIFO_DEPTH = 8
) (
	input  logic                    i_clk,
	input  logic                    i_arstN,
	input  logic                    i_push,
	input  mdecColorPkg::rgbPixel_t i_pixel,
	input  logic                    i_pop,
	output mdecColorPkg::rgbPixel_t o_pixel,
	output logic                    o_empty,
	output logic                    o_full
);

	import mdecColorPkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);

	rgbPixel_t  mem [FIFO_DEPTH];
	logic [AW:0] wrPtr;
	logic [AW:0] rdPtr;
	logic [AW:0] wrPtrNext;
	logic [AW:0] rdPtrNext;
	logic        doPush;
	logic        doPop;

	// A push into a full FIFO is lost
	assign doPush = i_push && !o_full;
	assign doPop  = i_pop && !o_empty;

	assign wrPtrNext = wrPtr + {{AW{1'b0}}, doPush};
	assign rdPtrNext = rdPtr + {{AW{1'b0}}, doPop};

	// Head of the queue
	assign o_pixel = mem[rdPtr[AW-1:0]];

	// ------------------------------------------------------------
	// Pointers and levels
	// ------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			o_empty <= 1'b1;
			o_full  <= 1'b0;
		end else begin
			wrPtr   <= wrPtrNext;
			rdPtr   <= rdPtrNext;
			o_empty <= (wrPtrNext == rdPtrNext);
			// Same slot, other lap
			o_full  <= (wrPtrNext[AW] != rdPtrNext[AW]) &&
				(wrPtrNext[AW-1:0] == rdPtrNext[AW-1:0]);
		end
	end

	always_ff @(posedge i_clk) begin
		if (doPush) begin
			mem[wrPtr[AW-1:0]] <= i_pixel;
		end
	end

	// Source must honour the full level seen at the top
	assert property (@(posedge i_clk) disable iff (!i_arstN) i_push |-> !o_full)
		else $error("pixelFifo push while full, pixel dropped");
	assert property (@(posedge i_clk) disable iff (!i_arstN) i_pop |-> !o_empty)
		else $error("pixelFifo pop while empty");

endmodule

//--- rtl/pixelPacker.sv
// Output word packer
// Pops a pixel whenever the FIFO holds one and builds 32-bit words
// 24-bit mode streams r, g, b bytes, four pixels give three words
// 15-bit mode puts two 5-5-5 pixels plus mask into one word
// A word leaves with o_wordValid one clock after its last pixel pops

`timescale 1ns/1ps

module pixelPacker (
	input  logic                    i_clk,
	input  logic                    i_arstN,
	input  logic                    i_empty,
	input  mdecColorPkg::rgbPixel_t i_pixel,
	input  mdecOutPkg::outFormat_t  i_format,
	input  logic                    i_setBit15,
	output logic                    o_pop,
	output logic                    o_wordValid,
	output mdecOutPkg::outWord_t    o_word,
	output logic                    o_pending
);

	import mdecColorPkg::*;
	import mdecOutPkg::*;

	localparam logic [GROUP_BITS-1:0] POS_ONE = 1;

	// Pixel index inside the current group
	logic [GROUP_BITS-1:0] groupPos;
	logic [GROUP_BITS-1:0] posNext;
	// Bytes of the word under construction
	outWord_t accWord;
	outWord_t accNext;
	outWord_t wordNext;
	logic     wordDone;
	rgb15_t   pix15;

	// No back-pressure from the output, drain as fast as possible
	assign o_pop = !i_empty;

	// Top bits of each channel
	assign pix15.mask = i_setBit15;
	assign pix15.b    = i_pixel.b[COLOR_BITS-1 -: FIELD15_BITS];
	assign pix15.g    = i_pixel.g[COLOR_BITS-1 -: FIELD15_BITS];
	assign pix15.r    = i_pixel.r[COLOR_BITS-1 -: FIELD15_BITS];

	// 15-bit toggles 0/1, 24-bit counts 0..3 and wraps
	assign posNext = (i_format == FMT_15) ? (groupPos ^ POS_ONE) : (groupPos + POS_ONE);

	// ------------------------------------------------------------
	// Next accumulator and completed word
	// ------------------------------------------------------------
	always_comb begin
		accNext  = accWord;
		wordNext = accWord;
		wordDone = 1'b0;
		if (i_format == FMT_15) begin
			if (!groupPos[0]) begin
				accNext.half[0] = pix15;
			end else begin
				wordNext.half[1] = pix15;
				wordDone         = 1'b1;
			end
		end else begin
			case (groupPos)
				2'd0: begin
					// Three bytes waiting
					accNext.bytes[0] = i_pixel.r;
					accNext.bytes[1] = i_pixel.g;
					accNext.bytes[2] = i_pixel.b;
				end
				2'd1: begin
					wordNext.bytes[3] = i_pixel.r;
					wordDone          = 1'b1;
					// g and b spill into the next word
					accNext.bytes[0]  = i_pixel.g;
					accNext.bytes[1]  = i_pixel.b;
				end
				2'd2: begin
					wordNext.bytes[2] = i_pixel.r;
					wordNext.bytes[3] = i_pixel.g;
					wordDone          = 1'b1;
					accNext.bytes[0]  = i_pixel.b;
				end
				default: begin
					// Last pixel of the group closes the third word
					wordNext.bytes[1] = i_pixel.r;
					wordNext.bytes[2] = i_pixel.g;
					wordNext.bytes[3] = i_pixel.b;
					wordDone          = 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			groupPos    <= '0;
			o_wordValid <= 1'b0;
		end else begin
			o_wordValid <= o_pop && wordDone;
			if (o_pop) begin
				groupPos <= posNext;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_pop) begin
			accWord <= accNext;
			if (wordDone) begin
				o_word <= wordNext;
			end
		end
	end

	// Partial group held, or a finished word still on the output
	assign o_pending = (groupPos != '0) || o_wordValid;

	// Switching format mid-group would corrupt the byte stream
	assert property (@(posedge i_clk) disable iff (!i_arstN)
		(groupPos != '0) |-> $stable(i_format))
		else $error("pixelPacker format changed while a word is pending");

endmodule

//--- rtl/mdecColorOut.sv
// MDEC colour output path
// Samples go through conversion, a pixel FIFO and the word packer
// o_inFull tells the source to hold off, o_busy covers any pixel in flight

`timescale 1ns/1ps

module mdecColorOut #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                     i_clk,
	input  logic                     i_arstN,
	input  logic                     i_sampleValid,
	input  mdecColorPkg::yuvSample_t i_sample,
	input  logic                     i_yOnly,
	input  logic                     i_unsigned,
	input  mdecOutPkg::outFormat_t   i_format,
	input  logic                     i_setBit15,
	output logic                     o_wordValid,
	output mdecOutPkg::outWord_t     o_word,
	output logic                     o_inFull,
	output logic                     o_busy
);

	import mdecColorPkg::*;

	// Stage to FIFO
	logic      push;
	rgbPixel_t stagePixel;
	// FIFO to packer
	logic      pop;
	logic      fifoEmpty;
	rgbPixel_t headPixel;
	logic      packPending;

	colorConvStage uStage (
		.i_clk        (i_clk),
		.i_arstN      (i_arstN),
		.i_sampleValid(i_sampleValid),
		.i_sample     (i_sample),
		.i_yOnly      (i_yOnly),
		.i_unsigned   (i_unsigned),
		.o_push       (push),
		.o_pixel      (stagePixel)
	);

	pixelFifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) uFifo (
		.i_clk  (i_clk),
		.i_arstN(i_arstN),
		.i_push (push),
		.i_pixel(stagePixel),
		.i_pop  (pop),
		.o_pixel(headPixel),
		.o_empty(fifoEmpty),
		.o_full (o_inFull)
	);

	pixelPacker uPacker (
		.i_clk      (i_clk),
		.i_arstN    (i_arstN),
		.i_empty    (fifoEmpty),
		.i_pixel    (headPixel),
		.i_format   (i_format),
		.i_setBit15 (i_setBit15),
		.o_pop      (pop),
		.o_wordValid(o_wordValid),
		.o_word     (o_word),
		.o_pending  (packPending)
	);

	// Pixel in the stage register counts as well
	assign o_busy = push || !fifoEmpty || packPending;

endmodule

//--- testbench/tbMdecColorOut.sv
// Testbench for the MDEC colour output path
// Directed tests for 24-bit and 15-bit packing, Y-only mode and a long burst
// A reference model computes each pixel from the conversion formula
// and the expected words from the byte and 15-bit layouts

`timescale 1ns/1ps

module tbMdecColorOut;

	import mdecColorPkg::*;
	import mdecOutPkg::*;

	localparam int TB_DEPTH       = 8;
	localparam int TIMEOUT_CYCLES = 500;

	logic       clk;
	logic       arstN;
	logic       sampleValid;
	yuvSample_t inSample;
	logic       yOnly;
	logic       unsignedMode;
	outFormat_t format;
	logic       setBit15;
	logic       wordValid;
	outWord_t   word;
	logic       inFull;
	logic       busy;

	int        seed;
	int        valueErrors;
	int        timeoutErrors;
	// Model pixels of the samples sent, words expected, words seen
	rgbPixel_t sentPixels[$];
	outWord_t  expWords[$];
	outWord_t  gotWords[$];
	outWord_t  signedWords[$];

	mdecColorOut #(
		.FIFO_DEPTH(TB_DEPTH)
	) u_dut (
		.i_clk        (clk),
		.i_arstN      (arstN),
		.i_sampleValid(sampleValid),
		.i_sample     (inSample),
		.i_yOnly      (yOnly),
		.i_unsigned   (unsignedMode),
		.i_format     (format),
		.i_setBit15   (setBit15),
		.o_wordValid  (wordValid),
		.o_word       (word),
		.o_inFull     (inFull),
		.o_busy       (busy)
	);

	always #5 clk = ~clk;

	// Monitor queues every emitted word in order
	always @(negedge clk) begin
		if (arstN && wordValid) begin
			gotWords.push_back(word);
		end
	end

	// ------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------
	task automatic checkWord(input string name, input outWord_t expVal, input outWord_t actVal);
		if (actVal !== expVal) begin
			valueErrors++;
			$display("FAILED %s: expected %h, actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkPixel(input string name, input rgbPixel_t expVal, input rgbPixel_t actVal);
		if (actVal !== expVal) begin
			valueErrors++;
			$display("FAILED %s: expected %h, actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkLevel(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal) begin
			valueErrors++;
			$display("FAILED %s: expected %b, actual %b", name, expVal, actVal);
		end
	endtask

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------
	// Clamp to -128..127 and offset by 128 in unsigned form
	function automatic logic [7:0] clampChannel(input integer v, input logic uns);
		integer c;
		c = (v > 127) ? 127 : ((v < -128) ? -128 : v);
		if (uns) begin
			c = c + 128;
		end
		return c[7:0];
	endfunction

	// Each chroma term is floored on its own before luma is added
	function automatic rgbPixel_t refPixel(input yuvSample_t s, input logic yo, input logic uns);
		integer    y;
		integer    cr;
		integer    cb;
		rgbPixel_t p;
		y  = $signed(s.y);
		cr = yo ? 0 : $signed(s.cr);
		cb = yo ? 0 : $signed(s.cb);
		p.r = clampChannel(y + ((cr * 359) >>> 8), uns);
		p.g = clampChannel(y + ((cb * -88) >>> 8) + ((cr * -183) >>> 8), uns);
		p.b = clampChannel(y + ((cb * 454) >>> 8), uns);
		return p;
	endfunction

	// Top five bits of each channel plus the mask
	function automatic rgb15_t to15(input rgbPixel_t p, input logic mask);
		rgb15_t h;
		h.mask = mask;
		h.b    = p.b[7:3];
		h.g    = p.g[7:3];
		h.r    = p.r[7:3];
		return h;
	endfunction

	function automatic yuvSample_t mkSample(input int y, input int cr, input int cb);
		yuvSample_t s;
		s.y  = y[7:0];
		s.cr = cr[7:0];
		s.cb = cb[7:0];
		return s;
	endfunction

	task automatic buildExpected(input outFormat_t fmt, input logic mask);
		logic [7:0] byteQ[$];
		outWord_t   w;
		if (fmt == FMT_24) begin
			// r, g, b per pixel, lowest byte first
			foreach (sentPixels[i]) begin
				byteQ.push_back(sentPixels[i].r);
				byteQ.push_back(sentPixels[i].g);
				byteQ.push_back(sentPixels[i].b);
			end
			for (int k = 0; k + 3 < byteQ.size(); k += 4) begin
				w.bytes[0] = byteQ[k];
				w.bytes[1] = byteQ[k + 1];
				w.bytes[2] = byteQ[k + 2];
				w.bytes[3] = byteQ[k + 3];
				expWords.push_back(w);
			end
		end else begin
			// Earlier pixel in the low half
			for (int k = 0; k + 1 < sentPixels.size(); k += 2) begin
				w.half[0] = to15(sentPixels[k], mask);
				w.half[1] = to15(sentPixels[k + 1], mask);
				expWords.push_back(w);
			end
		end
	endtask

	// ------------------------------------------------------------
	// Drivers
	// ------------------------------------------------------------
	task automatic setMode(input outFormat_t fmt, input logic yo, input logic uns,
		input logic b15);
		@(posedge clk);
		format       <= fmt;
		yOnly        <= yo;
		unsignedMode <= uns;
		setBit15     <= b15;
	endtask

	task automatic sendSample(input yuvSample_t s);
		int waitCount;
		waitCount = 0;
		@(negedge clk);
		// Hold the strobe off while the FIFO reports full
		while (inFull && waitCount < TIMEOUT_CYCLES) begin
			@(posedge clk);
			sampleValid <= 1'b0;
			@(negedge clk);
			waitCount++;
		end
		if (inFull) begin
			timeoutErrors++;
			$display("Timeout: o_inFull stayed high, a sample could not be sent");
		end else begin
			@(posedge clk);
			sampleValid <= 1'b1;
			inSample    <= s;
			sentPixels.push_back(refPixel(s, yOnly, unsignedMode));
		end
	endtask

	task automatic endSamples();
		@(posedge clk);
		sampleValid <= 1'b0;
	endtask

	task automatic clearQueues();
		sentPixels.delete();
		expWords.delete();
		gotWords.delete();
	endtask

	// Wait for all words and an idle path, then compare in order
	task automatic collectAndCheck(input string name);
		int waitCount;
		waitCount = 0;
		@(negedge clk);
		while (gotWords.size() < expWords.size() && waitCount < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waitCount++;
		end
		while (busy && waitCount < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waitCount++;
		end
		if (waitCount >= TIMEOUT_CYCLES) begin
			timeoutErrors++;
			$display("Timeout in %s: words missing or o_busy never fell", name);
		end
		checkLevel({name, " word count"}, 1'b1, gotWords.size() == expWords.size());
		foreach (expWords[i]) begin
			if (i < gotWords.size()) begin
				checkWord($sformatf("%s word %0d", name, i), expWords[i], gotWords[i]);
			end
		end
	endtask

	// ------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------
	task automatic testKnown24(input logic uns, input string name);
		clearQueues();
		setMode(FMT_24, 1'b0, uns, 1'b0);
		sendSample(mkSample(0, 0, 0));
		// Both extremes saturate r and b
		sendSample(mkSample(127, 127, 127));
		sendSample(mkSample(-128, -128, -128));
		sendSample(mkSample(40, -70, 90));
		endSamples();
		buildExpected(FMT_24, 1'b0);
		collectAndCheck(name);
	endtask

	task automatic testYOnly();
		rgbPixel_t  lumaPix[$];
		logic [7:0] byteQ[$];
		yuvSample_t s;
		rgbPixel_t  p;
		for (int uns = 0; uns < 2; uns++) begin
			clearQueues();
			lumaPix.delete();
			byteQ.delete();
			setMode(FMT_24, 1'b1, uns[0], 1'b0);
			for (int n = 0; n < 4; n++) begin
				s = 24'($random(seed));
				// Luma alone sets all three channels
				p.r = s.y + {uns[0], 7'b0};
				p.g = p.r;
				p.b = p.r;
				lumaPix.push_back(p);
				sendSample(s);
			end
			endSamples();
			buildExpected(FMT_24, 1'b0);
			collectAndCheck($sformatf("y-only uns=%0d", uns));
			foreach (gotWords[i]) begin
				for (int k = 0; k < 4; k++) begin
					byteQ.push_back(gotWords[i].bytes[k]);
				end
			end
			foreach (lumaPix[i]) begin
				if (3 * i + 2 < byteQ.size()) begin
					p.r = byteQ[3 * i];
					p.g = byteQ[3 * i + 1];
					p.b = byteQ[3 * i + 2];
					checkPixel($sformatf("y-only uns=%0d pixel %0d", uns, i), lumaPix[i], p);
				end
			end
		end
	endtask

	task automatic test15(input logic b15, input string name);
		clearQueues();
		setMode(FMT_15, 1'b0, 1'b1, b15);
		sendSample(mkSample(100, 20, -30));
		sendSample(mkSample(-60, 50, 10));
		sendSample(mkSample(127, -128, 127));
		sendSample(mkSample(5, 5, -5));
		endSamples();
		buildExpected(FMT_15, b15);
		collectAndCheck(name);
	endtask

	task automatic testBurst();
		int count;
		// Whole groups of four so the packer ends idle
		count = ((TB_DEPTH + 2 + 3) / 4) * 4;
		clearQueues();
		setMode(FMT_24, 1'b0, 1'b0, 1'b0);
		for (int n = 0; n < count; n++) begin
			sendSample(24'($random(seed)));
		end
		endSamples();
		buildExpected(FMT_24, 1'b0);
		@(negedge clk);
		// Last sample still on its way to the packer
		checkLevel("burst busy while draining", 1'b1, busy);
		collectAndCheck("burst");
		@(negedge clk);
		checkLevel("burst busy after last word", 1'b0, busy);
	endtask

	initial begin
		seed          = 32'hce76;
		valueErrors   = 0;
		timeoutErrors = 0;
		clk           = 1'b0;
		arstN         = 1'b0;
		sampleValid   = 1'b0;
		inSample      = '0;
		yOnly         = 1'b0;
		unsignedMode  = 1'b0;
		format        = FMT_24;
		setBit15      = 1'b0;
		repeat (8) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkLevel("reset wordValid", 1'b0, wordValid);
		checkLevel("reset inFull", 1'b0, inFull);
		checkLevel("reset busy", 1'b0, busy);

		testKnown24(1'b0, "24-bit signed");
		signedWords = expWords;
		testKnown24(1'b1, "24-bit unsigned");
		// Unsigned bytes differ from signed ones only in the top bit
		foreach (signedWords[i]) begin
			if (i < gotWords.size()) begin
				checkWord($sformatf("24-bit flip word %0d", i),
					outWord_t'(signedWords[i] ^ 32'h80808080), gotWords[i]);
			end
		end
		testYOnly();
		test15(1'b1, "15-bit mask set");
		test15(1'b0, "15-bit mask clear");
		testBurst();

		$display("Checks done: %0d value errors, %0d timeout errors", valueErrors, timeoutErrors);
		if (valueErrors == 0 && timeoutErrors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- build.f
rtl/mdecColorPkg.sv
rtl/mdecOutPkg.sv
rtl/YUV2RGBCompute.sv
rtl/colorConvStage.sv
rtl/pixelFifo.sv
rtl/pixelPacker.sv
rtl/mdecColorOut.sv
testbench/tbMdecColorOut.sv

//--- Makefile
# Verilator build and run for the MDEC colour output path
# Every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tbMdecColorOut
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
